/* tests/rs_trace.txt */
# t fl fb d op rd rob s1b s1t s1v s2b s2t s2v | lane0..3: v tag val | iv rob v1 v2 full empty
# one row per cycle, all fields hex, expected columns describe the cycle before its edge
1 0 1 1 33 01 1 0 0 11 0 0 12  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1
1 0 1 1 33 02 2 0 0 21 0 0 22  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
1 0 1 1 13 03 3 0 0 31 0 0 32  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
1 0 1 1 33 04 4 0 0 41 0 0 42  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
1 0 1 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 1 0
2 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 1 11 12 1 0
2 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 2 21 22 0 0
2 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 3 31 32 0 0
2 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 4 41 42 0 0
2 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1
3 0 0 1 33 05 5 1 5 00 0 0 52  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1
3 0 0 1 33 06 6 0 0 61 0 0 62  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
3 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 6 61 62 0 0
3 0 0 0 00 00 0 0 0 00 0 0 00  1 9 99 1 5 5a 0 0 0 1 5 ee  0 0 0 0 0 0
3 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 5 5a 52 0 0
3 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1
4 0 0 1 33 07 7 1 3 00 1 4 00  1 3 73 0 0 0 1 4 74 0 0 0  0 0 0 0 0 1
4 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  1 7 73 74 0 0
4 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1
5 0 1 1 33 08 8 0 0 81 0 0 82  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1
5 0 1 1 33 09 9 0 0 91 0 0 92  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
5 0 0 1 33 0a a 0 0 a1 0 0 a2  0 0 0 0 0 0 0 0 0 0 0 0  1 8 81 82 0 0
5 0 0 1 33 0b b 0 0 b1 0 0 b2  0 0 0 0 0 0 0 0 0 0 0 0  1 9 91 92 0 0
5 0 1 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
5 0 0 1 33 0c c 0 0 c1 0 0 c2  0 0 0 0 0 0 0 0 0 0 0 0  1 a a1 a2 0 0
5 1 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 0
5 0 0 0 00 00 0 0 0 00 0 0 00  0 0 0 0 0 0 0 0 0 0 0 0  0 0 0 0 0 1

/* project.f */
+incdir+verilog
verilog/rs_pkg.sv
verilog/rs_cdb_snoop.sv
verilog/rs_dispatch_capture.sv
verilog/rs_oldest_select.sv
verilog/rs_entry_array.sv
verilog/rs_top.sv
tests/rs_tb.sv

/* Makefile */
TOOL       := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wno-fatal
TOP        := rs_tb
FILELIST   := project.f
OBJDIR     := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tests/rs_tb.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_tb import rs_pkg::*; ();

        // fields per trace row, see the column list at the top of the trace
        localparam int FIELDS = 31;

        typedef logic [FIELDS-1:0][31:0] row_t;

        logic           clk;
        logic           rst;
        logic           flush;
        logic           fu_busy;
        logic           dispatch;
        rs_dispatch_t   dispatch_data;
        rs_cdb_bus_t    cdb;
        logic           issue_valid;
        rs_entry_t      issue_data;
        logic           full;
        logic           empty;

        row_t           rows[$];
        int             line_total;
        bit             trace_loaded;
        int             test_errors;
        int             total_errors;
        int             tests_passed;
        int             tests_failed;

        rs_top dut (
                .clk           (clk),
                .rst           (rst),
                .flush         (flush),
                .fu_busy       (fu_busy),
                .dispatch      (dispatch),
                .dispatch_data (dispatch_data),
                .cdb           (cdb),
                .issue_valid   (issue_valid),
                .issue_data    (issue_data),
                .full          (full),
                .empty         (empty)
        );

        // 8 ns period
        initial begin
                clk = 1'b0;
                forever #4 clk = ~clk;
        end

        // split one text line into hex fields, returns the field count
        function automatic int parse_row(input string line, output row_t row);
                int     n;
                int     start;
                bit     gap;
                n = 0;
                start = -1;
                row = '0;
                for (int i = 0; i <= line.len(); i++) begin
                        if (i == line.len())
                                gap = 1'b1;
                        else
                                gap = (line[i] == " " || line[i] == "\t" ||
                                       line[i] == "\n" || line[i] == "\r");
                        if (gap) begin
                                if (start >= 0) begin
                                        if (n < FIELDS)
                                                row[n] = line.substr(start, i - 1).atohex();
                                        n++;
                                        start = -1;
                                end
                        end else if (start < 0) begin
                                start = i;
                        end
                end
                return n;
        endfunction

        task automatic load_trace(output bit ok);
                int     fd;
                int     n;
                string  line;
                row_t   row;
                ok = 1'b0;
                fd = $fopen("tests/rs_trace.txt", "r");
                if (fd == 0) begin
                        $display("could not open tests/rs_trace.txt");
                end else begin
                        ok = 1'b1;
                        while (!$feof(fd)) begin
                                line = "";
                                if ($fgets(line, fd) == 0)
                                        break;
                                // comment lines start with a hash
                                if (line.len() > 0 && line[0] == "#")
                                        continue;
                                n = parse_row(line, row);
                                if (n == FIELDS) begin
                                        rows.push_back(row);
                                end else if (n != 0) begin
                                        $display("trace row has %0d fields, expected %0d", n, FIELDS);
                                        ok = 1'b0;
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic drive_row(input row_t r);
                flush                    = r[1][0];
                fu_busy                  = r[2][0];
                dispatch                 = r[3][0];
                // pc and imm stay zero, the station only carries them
                dispatch_data            = '0;
                dispatch_data.opcode     = r[4][`RS_OPC_W-1:0];
                dispatch_data.rd         = r[5][`RS_REG_W-1:0];
                dispatch_data.rob_entry  = r[6][`RS_TAG_W-1:0];
                dispatch_data.src1.busy  = r[7][0];
                dispatch_data.src1.tag   = r[8][`RS_TAG_W-1:0];
                dispatch_data.src1.value = r[9];
                dispatch_data.src2.busy  = r[10][0];
                dispatch_data.src2.tag   = r[11][`RS_TAG_W-1:0];
                dispatch_data.src2.value = r[12];
                // three columns per lane, lane 0 first
                for (int k = 0; k < `RS_CDB_PORTS; k++) begin
                        cdb[k].valid = r[13 + 3 * k][0];
                        cdb[k].tag   = r[14 + 3 * k][`RS_TAG_W-1:0];
                        cdb[k].value = r[15 + 3 * k];
                end
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] expected,
                                       input logic [31:0] actual);
                $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
                test_errors++;
        endtask

        task automatic check_row(input row_t r);
                if (issue_valid !== r[25][0])
                        report_mismatch("issue_valid", r[25], 32'(issue_valid));
                // payload only matters when an issue is expected
                if (r[25][0] && issue_valid) begin
                        if (issue_data.inst.rob_entry !== r[26][`RS_TAG_W-1:0])
                                report_mismatch("issue_data.rob_entry", r[26],
                                                32'(issue_data.inst.rob_entry));
                        if (issue_data.inst.src1.value !== r[27])
                                report_mismatch("issue_data.src1.value", r[27],
                                                issue_data.inst.src1.value);
                        if (issue_data.inst.src2.value !== r[28])
                                report_mismatch("issue_data.src2.value", r[28],
                                                issue_data.inst.src2.value);
                end
                if (full !== r[29][0])
                        report_mismatch("full", r[29], 32'(full));
                if (empty !== r[30][0])
                        report_mismatch("empty", r[30], 32'(empty));
        endtask

        task automatic finish_test(input logic [31:0] test_num);
                if (test_errors == 0) begin
                        $display("test %0d passed", test_num);
                        tests_passed++;
                end else begin
                        $display("test %0d failed with %0d mismatches", test_num, test_errors);
                        tests_failed++;
                end
                total_errors += test_errors;
                test_errors = 0;
        endtask

        initial begin : main_flow
                bit     loaded;
                row_t   r;
                rst           = 1'b1;
                flush         = 1'b0;
                fu_busy       = 1'b0;
                dispatch      = 1'b0;
                dispatch_data = '0;
                cdb           = '0;
                test_errors   = 0;
                total_errors  = 0;
                tests_passed  = 0;
                tests_failed  = 0;
                trace_loaded  = 1'b0;
                load_trace(loaded);
                line_total = rows.size();
                if (!loaded || line_total == 0) begin
                        $display("trace could not be used, no test was run");
                        $display("TEST FAIL");
                        $finish;
                end else begin
                        trace_loaded = 1'b1;
                        // two reset edges, release on a falling edge
                        repeat (2) @(posedge clk);
                        @(negedge clk);
                        rst = 1'b0;
                        for (int i = 0; i < line_total; i++) begin
                                r = rows[i];
                                drive_row(r);
                                // half way to the rising edge, outputs settled
                                #2;
                                check_row(r);
                                // last row of a test when the next number differs
                                if (i == line_total - 1 || rows[i + 1][0] != r[0])
                                        finish_test(r[0]);
                                @(negedge clk);
                        end
                        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                                 tests_passed, tests_failed, total_errors);
                        if (tests_failed == 0 && total_errors == 0)
                                $display("TEST PASS");
                        else
                                $display("TEST FAIL");
                        $finish;
                end
        end

        // one clock per trace row plus reset and slack
        initial begin : watchdog
                wait (trace_loaded);
                #(line_total * 8 + 100);
                $display("timeout, the trace of %0d rows did not finish in time", line_total);
                $display("TEST FAIL");
                $finish;
        end

endmodule

/* verilog/rs_top.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_top import rs_pkg::*; (
        input  logic            clk,
        input  logic            rst,
        input  logic            flush,
        // level from the functional unit
        input  logic            fu_busy,
        // one instruction per strobe
        input  logic            dispatch,
        input  rs_dispatch_t    dispatch_data,
        input  rs_cdb_bus_t     cdb,
        // unit takes issue_data on the edge where this is high
        output logic            issue_valid,
        output rs_entry_t       issue_data,
        output logic            full,
        output logic            empty
);

        rs_entry_t                      new_entry;
        rs_entry_t [`RS_DEPTH-1:0]      slots;
        logic [`RS_IDX_W-1:0]           sel_idx;

        // entry to insert, with same cycle bypass from the buses
        rs_dispatch_capture u_capture (
                .dispatch_data (dispatch_data),
                .cdb           (cdb),
                .new_entry     (new_entry)
        );

        rs_entry_array u_array (
                .clk       (clk),
                .rst       (rst),
                .flush     (flush),
                .dispatch  (dispatch),
                .new_entry (new_entry),
                .cdb       (cdb),
                .sel_valid (issue_valid),
                .sel_idx   (sel_idx),
                .slots     (slots),
                .full      (full),
                .empty     (empty)
        );

        // oldest ready slot goes out
        rs_oldest_select u_select (
                .slots     (slots),
                .fu_busy   (fu_busy),
                .flush     (flush),
                .sel_valid (issue_valid),
                .sel_idx   (sel_idx)
        );

        assign issue_data = slots[sel_idx];

endmodule

/* verilog/rs_entry_array.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_entry_array import rs_pkg::*; (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            flush,
        input  logic                            dispatch,
        input  rs_entry_t                       new_entry,
        input  rs_cdb_bus_t                     cdb,
        input  logic                            sel_valid,
        input  logic [`RS_IDX_W-1:0]            sel_idx,
        output rs_entry_t [`RS_DEPTH-1:0]       slots,
        output logic                            full,
        output logic                            empty
);

        logic [`RS_CNT_W-1:0]           count;
        logic [`RS_CNT_W-1:0]           count_after;
        logic [`RS_CNT_W-1:0]           count_next;
        logic [`RS_IDX_W-1:0]           ins_pos;
        logic                           accept;
        rs_operand_t [`RS_DEPTH-1:0]    wake_src1;
        rs_operand_t [`RS_DEPTH-1:0]    wake_src2;
        rs_entry_t [`RS_DEPTH-1:0]      woken;
        rs_entry_t [`RS_DEPTH-1:0]      slots_next;
        logic [`RS_DEPTH-1:0]           valid_vec;
        logic [`RS_DEPTH-1:0]           valid_inc;

        // one wakeup snooper per source per slot
        for (genvar g = 0; g < `RS_DEPTH; g++) begin : g_wake
                rs_cdb_snoop u_snoop_src1 (
                        .operand_in  (slots[g].inst.src1),
                        .cdb         (cdb),
                        .operand_out (wake_src1[g])
                );

                rs_cdb_snoop u_snoop_src2 (
                        .operand_in  (slots[g].inst.src2),
                        .cdb         (cdb),
                        .operand_out (wake_src2[g])
                );

                assign valid_vec[g] = slots[g].valid;
        end

        assign full  = (count == `RS_CNT_W'(`RS_DEPTH));
        assign empty = (count == '0);

        // a full station drops the dispatch even if something issues now
        assign accept = dispatch && !full && !flush;

        // occupancy once the issued entry has left
        assign count_after = count - {{(`RS_CNT_W-1){1'b0}}, sel_valid};
        assign count_next  = count_after + {{(`RS_CNT_W-1){1'b0}}, accept};

        // new entry lands right behind the last survivor
        // count_after is below RS_DEPTH whenever a dispatch is accepted
        assign ins_pos = count_after[`RS_IDX_W-1:0];

        always_comb begin
                // wakeup first
                for (int i = 0; i < `RS_DEPTH; i++) begin
                        woken[i]           = slots[i];
                        woken[i].inst.src1 = wake_src1[i];
                        woken[i].inst.src2 = wake_src2[i];
                end
                // collapse above the issued slot
                for (int i = 0; i < `RS_DEPTH - 1; i++) begin
                        if (sel_valid && (i >= int'(sel_idx)))
                                slots_next[i] = woken[i + 1];
                        else
                                slots_next[i] = woken[i];
                end
                // top slot empties on any issue
                if (sel_valid)
                        slots_next[`RS_DEPTH-1] = '0;
                else
                        slots_next[`RS_DEPTH-1] = woken[`RS_DEPTH-1];
                // insert goes in after the shift
                if (accept)
                        slots_next[ins_pos] = new_entry;
        end

        always_ff @(posedge clk) begin
                if (rst || flush) begin
                        count <= '0;
                        // every slot goes invalid
                        for (int i = 0; i < `RS_DEPTH; i++)
                                slots[i].valid <= 1'b0;
                end else begin
                        count <= count_next;
                        slots <= slots_next;
                end
        end

        // used to check that the valid bits form one run from slot 0
        assign valid_inc = valid_vec + 1'b1;

        a_count_bound: assert property (@(posedge clk) disable iff (rst)
                count <= `RS_CNT_W'(`RS_DEPTH));

        // count and the valid run from slot 0 must agree
        a_contiguous: assert property (@(posedge clk) disable iff (rst)
                ((valid_vec & valid_inc) == '0) && ($countones(valid_vec) == int'(count)));

        a_no_drop: assert property (@(posedge clk) disable iff (rst)
                dispatch |-> !full);

        // select must point at a live slot or the collapse eats a hole
        a_issue_live: assert property (@(posedge clk) disable iff (rst)
                sel_valid |-> slots[sel_idx].valid);

endmodule

/* verilog/rs_oldest_select.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_oldest_select import rs_pkg::*; (
        input  rs_entry_t [`RS_DEPTH-1:0]       slots,
        input  logic                            fu_busy,
        input  logic                            flush,
        output logic                            sel_valid,
        output logic [`RS_IDX_W-1:0]            sel_idx
);

        logic found;

        // slot 0 is always the oldest, the array collapses toward it
        always_comb begin
                found   = 1'b0;
                sel_idx = '0;
                // high to low, last hit is the lowest index
                for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
                        if (slots[i].valid && !slots[i].inst.src1.busy &&
                            !slots[i].inst.src2.busy) begin
                                found   = 1'b1;
                                sel_idx = i[`RS_IDX_W-1:0];
                        end
                end
        end

        // hold off while the unit is busy
        // and never issue into a flush
        assign sel_valid = found && !fu_busy && !flush;

endmodule

/* verilog/rs_dispatch_capture.sv */
`timescale 1ns/1ps

module rs_dispatch_capture import rs_pkg::*; (
        input  rs_dispatch_t    dispatch_data,
        input  rs_cdb_bus_t     cdb,
        output rs_entry_t       new_entry
);

        rs_operand_t src1_snooped;
        rs_operand_t src2_snooped;

        // a producer may broadcast in the very cycle we dispatch
        // so both sources look at this cycle's lanes too
        rs_cdb_snoop u_snoop_src1 (
                .operand_in  (dispatch_data.src1),
                .cdb         (cdb),
                .operand_out (src1_snooped)
        );

        rs_cdb_snoop u_snoop_src2 (
                .operand_in  (dispatch_data.src2),
                .cdb         (cdb),
                .operand_out (src2_snooped)
        );

        always_comb begin
                // everything else goes in untouched
                // opcode is carried along, never looked at here
                new_entry.valid     = 1'b1;
                new_entry.inst      = dispatch_data;
                new_entry.inst.src1 = src1_snooped;
                new_entry.inst.src2 = src2_snooped;
        end

endmodule

/* verilog/rs_cdb_snoop.sv */
`timescale 1ns/1ps
`include "rs_params.svh"

module rs_cdb_snoop import rs_pkg::*; (
        input  rs_operand_t     operand_in,
        input  rs_cdb_bus_t     cdb,
        output rs_operand_t     operand_out
);

        always_comb begin
                // default: operand unchanged
                operand_out = operand_in;
                // walk lanes high to low
                // so the lowest matching lane is applied last and wins
                for (int i = `RS_CDB_PORTS - 1; i >= 0; i--) begin
                        if (operand_in.busy && cdb[i].valid &&
                            (cdb[i].tag == operand_in.tag)) begin
                                operand_out.busy  = 1'b0;
                                operand_out.value = cdb[i].value;
                        end
                end
                // tag is kept as is, harmless once busy drops
        end

endmodule

/* verilog/rs_pkg.sv */
`include "rs_params.svh"

package rs_pkg;

        // one source operand, value is meaningful once busy is low
        typedef struct packed {
                logic                   busy;
                logic [`RS_TAG_W-1:0]   tag;
                logic [`RS_XLEN-1:0]    value;
        } rs_operand_t;

        // one common data bus lane
        typedef struct packed {
                logic                   valid;
                logic [`RS_TAG_W-1:0]   tag;
                logic [`RS_XLEN-1:0]    value;
        } rs_cdb_t;

        // all lanes, lane 0 in the low bits
        typedef rs_cdb_t [`RS_CDB_PORTS-1:0] rs_cdb_bus_t;

        // fields handed over by dispatch
        typedef struct packed {
                logic [`RS_OPC_W-1:0]   opcode;
                logic [`RS_ALUOP_W-1:0] aluop;
                logic [`RS_CMPOP_W-1:0] cmpop;
                logic [`RS_MULOP_W-1:0] mulop;
                logic [`RS_REG_W-1:0]   rd;
                // rob slot this instruction will write
                logic [`RS_TAG_W-1:0]   rob_entry;
                rs_operand_t            src1;
                rs_operand_t            src2;
                logic [`RS_XLEN-1:0]    pc;
                logic [`RS_XLEN-1:0]    imm;
        } rs_dispatch_t;

        // one station slot
        typedef struct packed {
                logic                   valid;
                rs_dispatch_t           inst;
        } rs_entry_t;

endpackage

/* verilog/rs_params.svh */
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// station geometry
`define RS_DEPTH        4
// count runs 0..RS_DEPTH so it needs one bit more than the index
`define RS_CNT_W        3
`define RS_IDX_W        2

// result broadcast lanes
`define RS_CDB_PORTS    4

// reorder buffer tag and data word
`define RS_TAG_W        4
`define RS_XLEN         32

// decoded instruction fields
`define RS_OPC_W        7
`define RS_ALUOP_W      3
`define RS_CMPOP_W      3
`define RS_MULOP_W      2
`define RS_REG_W        5

`endif
